//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////
    // geometry
    ////////////////////

    localparam int WORD_W   = 32;
    localparam int BANKS    = 8;
    localparam int WAYS     = 2;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;
    localparam int LINE_W   = BANKS * WORD_W;
    localparam int SETS     = 1 << INDEX_W;

    ////////////////////
    // vector types
    ////////////////////

    typedef logic [31:0]         addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [2:0]          bank_sel_t;
    typedef logic [WORD_W/8-1:0] wsel_t;
    typedef logic                way_t;

    // one cpu access, rd and wr are never both set
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
        wsel_t wsel;
    } cpu_req_t;

    // victim line, addr is line aligned
    typedef struct packed {
        addr_t addr;
        line_t line;
    } wb_entry_t;

    typedef enum logic [0:0] {
        LOOKUP,
        FETCH
    } cache_state_e;

endpackage

`default_nettype wire

//--- verilog/writeback_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_i,
    input  dcache_pkg::wb_entry_t entry_i,
    input  logic                  mem_bvalid_i,
    output logic                  full_o,
    output logic                  mem_wen_o,
    output dcache_pkg::addr_t     mem_awaddr_o,
    output dcache_pkg::line_t     mem_wdata_o
);

    logic                  full_q;
    dcache_pkg::wb_entry_t entry_q;

    ////////////////////
    // occupancy
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (!full_q && push_i) begin
            full_q <= 1'b1;
        end else if (full_q && mem_bvalid_i) begin
            // memory took the line
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!full_q && push_i) begin
            entry_q <= entry_i;
        end
    end

    ////////////////////
    // memory write channel
    ////////////////////

    // request stays up with steady data until the ack
    assign mem_wen_o    = full_q;
    assign mem_awaddr_o = entry_q.addr;
    assign mem_wdata_o  = entry_q.line;
    assign full_o       = full_q;

endmodule

`default_nettype wire

//--- dcache/dcache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_data_array (
    input  logic                                   clk,
    input  dcache_pkg::index_t                     index_i,
    input  dcache_pkg::wsel_t [dcache_pkg::WAYS-1:0][dcache_pkg::BANKS-1:0] we_i,
    input  dcache_pkg::line_t                      wdata_i,
    output dcache_pkg::line_t [dcache_pkg::WAYS-1:0] line_o
);

    ////////////////////
    // one ram per bank per way
    ////////////////////

    for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
        for (genvar b = 0; b < dcache_pkg::BANKS; b++) begin : g_bank

            dcache_pkg::word_t ram_q [dcache_pkg::SETS];
            dcache_pkg::word_t rd_q;

            // byte writes, read returns the old word on a collision
            always_ff @(posedge clk) begin
                for (int i = 0; i < dcache_pkg::WORD_W / 8; i++) begin
                    if (we_i[w][b][i]) begin
                        ram_q[index_i][i * 8 +: 8] <= wdata_i[b * dcache_pkg::WORD_W + i * 8 +: 8];
                    end
                end
                rd_q <= ram_q[index_i];
            end

            assign line_o[w][b * dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = rd_q;

        end
    end

endmodule

`default_nettype wire

//--- dcache/dcache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store (
    input  logic                                   clk,
    input  logic                                   rst,
    input  dcache_pkg::index_t                     index_i,
    input  logic [dcache_pkg::WAYS-1:0]            tag_we_i,
    input  dcache_pkg::tag_t                       tag_wdata_i,
    input  logic                                   dirty_we_i,
    input  dcache_pkg::way_t                       dirty_way_i,
    input  logic                                   dirty_val_i,
    input  logic                                   lru_we_i,
    input  dcache_pkg::way_t                       lru_val_i,
    output dcache_pkg::tag_t [dcache_pkg::WAYS-1:0] tag_o,
    output logic [dcache_pkg::WAYS-1:0]            valid_o,
    output logic                                   dirty_o,
    output dcache_pkg::way_t                       lru_o
);

    dcache_pkg::tag_t            tag_q   [dcache_pkg::WAYS][dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0] valid_q [dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0] dirty_q [dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0] lru_q;

    ////////////////////
    // tag and valid
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
                for (int s = 0; s < dcache_pkg::SETS; s++) begin
                    tag_q[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                // a refilled line is valid from the next read on
                if (tag_we_i[w]) begin
                    tag_q[w][index_i]   <= tag_wdata_i;
                    valid_q[w][index_i] <= 1'b1;
                end
            end
        end
    end

    // synchronous read, data lines up with the bank rams
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            tag_o[w]   <= tag_q[w][index_i];
            valid_o[w] <= valid_q[w][index_i];
        end
    end

    ////////////////////
    // dirty and lru
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (dirty_we_i) begin
                dirty_q[dirty_way_i][index_i] <= dirty_val_i;
            end
            if (lru_we_i) begin
                lru_q[index_i] <= lru_val_i;
            end
        end
    end

    // combinational, dirty state of the current victim
    assign lru_o   = lru_q[index_i];
    assign dirty_o = dirty_q[lru_o][index_i];

endmodule

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,
    input  dcache_pkg::cpu_req_t                   cpu_req_i,
    input  dcache_pkg::tag_t [dcache_pkg::WAYS-1:0] tagv_tag_i,
    input  logic [dcache_pkg::WAYS-1:0]            tagv_valid_i,
    input  logic                                   dirty_i,
    input  dcache_pkg::way_t                       lru_i,
    input  dcache_pkg::line_t [dcache_pkg::WAYS-1:0] line_rd_i,
    input  logic                                   mem_rvalid_i,
    input  dcache_pkg::line_t                      mem_rdata_i,
    input  logic                                   wb_full_i,
    output logic                                   hit_o,
    output logic                                   cpu_data_valid_o,
    output dcache_pkg::word_t                      cpu_rdata_o,
    output logic                                   cpu_stall_o,
    output dcache_pkg::index_t                     ram_index_o,
    output dcache_pkg::wsel_t [dcache_pkg::WAYS-1:0][dcache_pkg::BANKS-1:0] bank_we_o,
    output dcache_pkg::line_t                      bank_wdata_o,
    output logic [dcache_pkg::WAYS-1:0]            tag_we_o,
    output dcache_pkg::tag_t                       tag_wdata_o,
    output logic                                   dirty_we_o,
    output dcache_pkg::way_t                       dirty_way_o,
    output logic                                   dirty_val_o,
    output logic                                   lru_we_o,
    output dcache_pkg::way_t                       lru_val_o,
    output logic                                   mem_ren_o,
    output dcache_pkg::addr_t                      mem_araddr_o,
    output logic                                   wb_push_o,
    output dcache_pkg::wb_entry_t                  wb_entry_o
);

    localparam int BANK_LSB = $clog2(dcache_pkg::WORD_W / 8);
    localparam int TAG_LSB  = dcache_pkg::OFFSET_W + dcache_pkg::INDEX_W;

    dcache_pkg::cache_state_e    state_q;
    dcache_pkg::cache_state_e    state_d;
    dcache_pkg::cpu_req_t        req_q;
    logic                        accept;
    logic                        in_fetch;
    dcache_pkg::tag_t            req_tag;
    dcache_pkg::index_t          req_index;
    dcache_pkg::bank_sel_t       req_bank;
    logic [dcache_pkg::WAYS-1:0] hit_way;
    logic                        hit;
    logic                        refill;
    dcache_pkg::way_t            hit_num;
    dcache_pkg::way_t            victim;
    dcache_pkg::way_t            touched;
    dcache_pkg::line_t           refill_line;
    dcache_pkg::line_t           hit_line;

    // replace the selected bytes of one word in a line
    function automatic dcache_pkg::line_t merge_word(
        input dcache_pkg::line_t     line,
        input dcache_pkg::bank_sel_t bank,
        input dcache_pkg::word_t     wdata,
        input dcache_pkg::wsel_t     wsel
    );
        dcache_pkg::line_t merged;
        merged = line;
        for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
            if (wsel[b]) begin
                merged[bank * dcache_pkg::WORD_W + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////
    // request latch and fsm
    ////////////////////

    assign accept   = (state_q == dcache_pkg::LOOKUP) && (cpu_req_i.rd || cpu_req_i.wr);
    assign in_fetch = (state_q == dcache_pkg::FETCH);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        if (accept) begin
            state_d = dcache_pkg::FETCH;
        end else if (in_fetch && (hit || refill)) begin
            state_d = dcache_pkg::LOOKUP;
        end
    end

    assign req_tag   = req_q.addr[TAG_LSB +: dcache_pkg::TAG_W];
    assign req_index = req_q.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign req_bank  = req_q.addr[BANK_LSB +: 3];

    // incoming index while idle so the arrays are ready in the first fetch cycle
    assign ram_index_o = in_fetch ? req_index
                                  : cpu_req_i.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];

    ////////////////////
    // hit and victim
    ////////////////////

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            hit_way[w] = tagv_valid_i[w] && (tagv_tag_i[w] == req_tag);
        end
    end

    assign hit     = in_fetch && (|hit_way);
    assign hit_num = hit_way[1];
    assign victim  = lru_i;
    assign refill  = in_fetch && !hit && mem_rvalid_i;
    assign touched = hit ? hit_num : victim;

    assign refill_line = req_q.wr ? merge_word(mem_rdata_i, req_bank, req_q.wdata, req_q.wsel)
                                  : mem_rdata_i;
    assign hit_line    = merge_word(line_rd_i[hit_num], req_bank, req_q.wdata, req_q.wsel);

    ////////////////////
    // array updates
    ////////////////////

    always_comb begin
        bank_we_o = '0;
        tag_we_o  = '0;
        if (refill) begin
            bank_we_o[victim] = '1;
            tag_we_o[victim]  = 1'b1;
        end else if (hit && req_q.wr) begin
            bank_we_o[hit_num][req_bank] = req_q.wsel;
        end
    end

    assign bank_wdata_o = hit ? hit_line : refill_line;
    assign tag_wdata_o  = req_tag;

    // write marks the line dirty, a read refill leaves it clean
    assign dirty_we_o  = refill || (hit && req_q.wr);
    assign dirty_way_o = touched;
    assign dirty_val_o = req_q.wr;

    assign lru_we_o  = hit || refill;
    assign lru_val_o = ~touched;

    ////////////////////
    // memory and victim
    ////////////////////

    // hold off the refill while a dirty victim has nowhere to go
    assign mem_ren_o    = in_fetch && !hit && !mem_rvalid_i && !(dirty_i && wb_full_i);
    assign mem_araddr_o = {req_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};

    assign wb_push_o       = refill && dirty_i;
    assign wb_entry_o.addr = {tagv_tag_i[victim], req_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wb_entry_o.line = line_rd_i[victim];

    ////////////////////
    // cpu response
    ////////////////////

    assign hit_o            = hit;
    assign cpu_data_valid_o = !req_q.wr && (hit || refill);
    assign cpu_rdata_o      = hit ? line_rd_i[hit_num][req_bank * dcache_pkg::WORD_W +: dcache_pkg::WORD_W]
                                  : refill_line[req_bank * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    assign cpu_stall_o      = in_fetch;

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    // cpu side
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output logic                 hit_o,
    output logic                 cpu_data_valid_o,
    output dcache_pkg::word_t    cpu_rdata_o,
    output logic                 cpu_stall_o,
    // memory read
    output logic                 mem_ren_o,
    output dcache_pkg::addr_t    mem_araddr_o,
    input  logic                 mem_rvalid_i,
    input  dcache_pkg::line_t    mem_rdata_i,
    // memory write
    output logic                 mem_wen_o,
    output dcache_pkg::addr_t    mem_awaddr_o,
    output dcache_pkg::line_t    mem_wdata_o,
    input  logic                 mem_bvalid_i
);

    dcache_pkg::index_t                                         ram_index;
    dcache_pkg::wsel_t [dcache_pkg::WAYS-1:0][dcache_pkg::BANKS-1:0] bank_we;
    dcache_pkg::line_t                                          bank_wdata;
    dcache_pkg::line_t [dcache_pkg::WAYS-1:0]                   line_rd;
    logic [dcache_pkg::WAYS-1:0]                                tag_we;
    dcache_pkg::tag_t                                           tag_wdata;
    dcache_pkg::tag_t [dcache_pkg::WAYS-1:0]                    tag_rd;
    logic [dcache_pkg::WAYS-1:0]                                valid_rd;
    logic                                                       dirty_we;
    dcache_pkg::way_t                                           dirty_way;
    logic                                                       dirty_val;
    logic                                                       dirty_rd;
    logic                                                       lru_we;
    dcache_pkg::way_t                                           lru_val;
    dcache_pkg::way_t                                           lru_rd;
    logic                                                       wb_push;
    dcache_pkg::wb_entry_t                                      wb_entry;
    logic                                                       wb_full;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_i        (cpu_req_i),
        .tagv_tag_i       (tag_rd),
        .tagv_valid_i     (valid_rd),
        .dirty_i          (dirty_rd),
        .lru_i            (lru_rd),
        .line_rd_i        (line_rd),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .wb_full_i        (wb_full),
        .hit_o            (hit_o),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_rdata_o      (cpu_rdata_o),
        .cpu_stall_o      (cpu_stall_o),
        .ram_index_o      (ram_index),
        .bank_we_o        (bank_we),
        .bank_wdata_o     (bank_wdata),
        .tag_we_o         (tag_we),
        .tag_wdata_o      (tag_wdata),
        .dirty_we_o       (dirty_we),
        .dirty_way_o      (dirty_way),
        .dirty_val_o      (dirty_val),
        .lru_we_o         (lru_we),
        .lru_val_o        (lru_val),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .wb_push_o        (wb_push),
        .wb_entry_o       (wb_entry)
    );

    dcache_data_array u_data_array (
        .clk     (clk),
        .index_i (ram_index),
        .we_i    (bank_we),
        .wdata_i (bank_wdata),
        .line_o  (line_rd)
    );

    dcache_tag_store u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .index_i     (ram_index),
        .tag_we_i    (tag_we),
        .tag_wdata_i (tag_wdata),
        .dirty_we_i  (dirty_we),
        .dirty_way_i (dirty_way),
        .dirty_val_i (dirty_val),
        .lru_we_i    (lru_we),
        .lru_val_i   (lru_val),
        .tag_o       (tag_rd),
        .valid_o     (valid_rd),
        .dirty_o     (dirty_rd),
        .lru_o       (lru_rd)
    );

    writeback_buffer u_wb_buf (
        .clk          (clk),
        .rst          (rst),
        .push_i       (wb_push),
        .entry_i      (wb_entry),
        .mem_bvalid_i (mem_bvalid_i),
        .full_o       (wb_full),
        .mem_wen_o    (mem_wen_o),
        .mem_awaddr_o (mem_awaddr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

    logic                  clk;
    logic                  rst;
    dcache_pkg::cpu_req_t  cpu_req;
    logic                  hit_o;
    logic                  cpu_data_valid_o;
    dcache_pkg::word_t     cpu_rdata_o;
    logic                  cpu_stall_o;
    logic                  mem_ren_o;
    dcache_pkg::addr_t     mem_araddr_o;
    logic                  mem_rvalid_i;
    dcache_pkg::line_t     mem_rdata_i;
    logic                  mem_wen_o;
    dcache_pkg::addr_t     mem_awaddr_o;
    dcache_pkg::line_t     mem_wdata_o;
    logic                  mem_bvalid_i;

    logic [15:0]           lfsr_q = 16'd49678;
    dcache_pkg::word_t     shadow [logic [29:0]];
    dcache_pkg::line_t     mem_lines [dcache_pkg::addr_t];
    int                    checks = 0;
    int                    errors = 0;
    int                    timeouts = 0;
    int                    wb_count = 0;
    dcache_pkg::addr_t     last_wb_addr;
    dcache_pkg::addr_t     req_line_addr;
    logic                  rd_busy;
    int                    rd_delay;
    dcache_pkg::addr_t     rd_addr;
    logic                  wr_busy;
    int                    wr_delay;

    dcache_top DUT (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_i        (cpu_req),
        .hit_o            (hit_o),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_rdata_o      (cpu_rdata_o),
        .cpu_stall_o      (cpu_stall_o),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .mem_wen_o        (mem_wen_o),
        .mem_awaddr_o     (mem_awaddr_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_bvalid_i     (mem_bvalid_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // galois lfsr stepped once per bit taken
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // power-on memory content from the whole word address
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t a);
        dcache_pkg::word_t w;
        w = {a[31:2], 2'b00};
        return (w * 32'h9E37_79B1) ^ 32'hA5C3_0F69;
    endfunction

    // expected word as seen by the cpu
    function automatic dcache_pkg::word_t ref_word(input dcache_pkg::addr_t a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return init_word(a);
    endfunction

    function automatic dcache_pkg::line_t load_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int b = 0; b < dcache_pkg::BANKS; b++) begin
            l[b * 32 +: 32] = init_word(a + 32'(b * 4));
        end
        return l;
    endfunction

    function automatic dcache_pkg::addr_t mk_addr(input dcache_pkg::tag_t t,
                                                  input dcache_pkg::index_t i,
                                                  input dcache_pkg::bank_sel_t b);
        return {t, i, b, 2'b00};
    endfunction

    task automatic check_val(input string what, input logic [255:0] got,
                             input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic apply_write(input dcache_pkg::addr_t a, input dcache_pkg::word_t wd,
                               input dcache_pkg::wsel_t ws);
        dcache_pkg::word_t w;
        w = ref_word(a);
        for (int b = 0; b < 4; b++) begin
            if (ws[b]) begin
                w[b * 8 +: 8] = wd[b * 8 +: 8];
            end
        end
        shadow[a[31:2]] = w;
    endtask

    ////////////////////
    // memory model
    ////////////////////

    always @(negedge clk) begin
        if (!rst && mem_ren_o && !rd_busy) begin
            check_val("refill address", mem_araddr_o, req_line_addr);
            rd_busy  = 1'b1;
            rd_addr  = mem_araddr_o;
            rd_delay = 1 + rand_bits(3) % 6;
        end
        // the line lands in memory at once and the ack follows later
        if (!rst && mem_wen_o && !wr_busy) begin
            check_val("writeback address align", mem_awaddr_o[4:0], 0);
            for (int b = 0; b < dcache_pkg::BANKS; b++) begin
                check_val("writeback word", mem_wdata_o[b * 32 +: 32],
                          ref_word(mem_awaddr_o + 32'(b * 4)));
            end
            mem_lines[mem_awaddr_o] = mem_wdata_o;
            last_wb_addr = mem_awaddr_o;
            wb_count++;
            wr_busy  = 1'b1;
            wr_delay = 1 + rand_bits(2);
        end
    end

    always @(posedge clk) begin
        #1;
        mem_rvalid_i = 1'b0;
        if (rst) begin
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            mem_bvalid_i = 1'b0;
        end else begin
            if (rd_busy) begin
                if (rd_delay == 1) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = load_line(rd_addr);
                    rd_busy      = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            if (mem_bvalid_i) begin
                mem_bvalid_i = 1'b0;
                wr_busy      = 1'b0;
            end else if (wr_busy) begin
                if (wr_delay == 1) begin
                    mem_bvalid_i = 1'b1;
                end else begin
                    wr_delay--;
                end
            end
        end
    end

    ////////////////////
    // cpu side
    ////////////////////

    // exp_hit is 0 for a miss, 1 for a hit and 2 for either
    task automatic do_op(input logic wr, input dcache_pkg::addr_t a,
                         input dcache_pkg::word_t wd, input dcache_pkg::wsel_t ws,
                         input int exp_hit);
        dcache_pkg::word_t exp_word;
        dcache_pkg::word_t got;
        int                cyc;
        int                hit_cyc;
        logic              done;
        logic              saw_valid;
        logic              saw_ren;
        if (wr) begin
            apply_write(a, wd, ws);
        end
        exp_word = ref_word(a);
        req_line_addr = {a[31:5], 5'b0};
        cyc = 0;
        hit_cyc = 0;
        done = 1'b0;
        saw_valid = 1'b0;
        saw_ren = 1'b0;
        @(posedge clk);
        #1;
        cpu_req.rd    = !wr;
        cpu_req.wr    = wr;
        cpu_req.addr  = a;
        cpu_req.wdata = wd;
        cpu_req.wsel  = ws;
        @(posedge clk);
        #1;
        cpu_req.rd = 1'b0;
        cpu_req.wr = 1'b0;
        while (!done) begin
            @(negedge clk);
            cyc++;
            if (cyc > 40) begin
                $display("timeout: request to %h never completed", a);
                timeouts++;
                return;
            end
            check_val("stall during request", cpu_stall_o, 1);
            if (mem_ren_o) begin
                saw_ren = 1'b1;
            end
            if (hit_o && hit_cyc == 0) begin
                hit_cyc = cyc;
            end
            if (cpu_data_valid_o) begin
                saw_valid = 1'b1;
                got = cpu_rdata_o;
            end
            done = hit_o || mem_rvalid_i;
        end
        @(negedge clk);
        check_val("stall after completion", cpu_stall_o, 0);
        check_val("read data valid", saw_valid, !wr);
        if (!wr && saw_valid) begin
            check_val("read data", got, exp_word);
        end
        if (exp_hit == 1) begin
            check_val("hit cycle", hit_cyc, 1);
            check_val("memory read on hit", saw_ren, 0);
        end else if (exp_hit == 0) begin
            check_val("hit on expected miss", hit_cyc, 0);
            check_val("memory read on miss", saw_ren, 1);
        end
        // let the memory model see this edge before the next request
        #1;
    endtask

    task automatic wait_wb_idle();
        int cyc;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc > 50) begin
                $display("timeout: write-back buffer never drained");
                timeouts++;
                return;
            end
        end while (mem_wen_o || wr_busy);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        dcache_pkg::addr_t a;
        int                n0;
        logic              op_wr;
        cpu_req      = '0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_bvalid_i = 1'b0;
        rst          = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // cold miss, then hit, then byte writes on hit and miss
        a = mk_addr(20'h12345, 7'd10, 3'd3);
        do_op(1'b0, a, '0, '0, 0);
        do_op(1'b0, a, '0, '0, 1);
        do_op(1'b1, mk_addr(20'h12345, 7'd10, 3'd6), rand_bits(32),
              dcache_pkg::wsel_t'(rand_bits(4)), 1);
        do_op(1'b0, mk_addr(20'h12345, 7'd10, 3'd6), '0, '0, 1);
        do_op(1'b1, mk_addr(20'h0BEEF, 7'd11, 3'd1), rand_bits(32), 4'b0110, 0);
        do_op(1'b0, mk_addr(20'h0BEEF, 7'd11, 3'd1), '0, '0, 1);

        // lru replacement in one set
        do_op(1'b0, mk_addr(20'h00A01, 7'd20, 3'd0), '0, '0, 0);
        do_op(1'b0, mk_addr(20'h00B02, 7'd20, 3'd1), '0, '0, 0);
        do_op(1'b0, mk_addr(20'h00A01, 7'd20, 3'd2), '0, '0, 1);
        do_op(1'b0, mk_addr(20'h00C03, 7'd20, 3'd3), '0, '0, 0);
        do_op(1'b0, mk_addr(20'h00A01, 7'd20, 3'd4), '0, '0, 1);
        do_op(1'b0, mk_addr(20'h00B02, 7'd20, 3'd5), '0, '0, 0);
        do_op(1'b0, mk_addr(20'h00A01, 7'd20, 3'd7), '0, '0, 1);

        // dirty victim goes to memory while a clean one does not
        do_op(1'b1, mk_addr(20'h0D001, 7'd40, 3'd2), 32'hCAFE_F00D, 4'b1111, 0);
        do_op(1'b0, mk_addr(20'h0D002, 7'd40, 3'd0), '0, '0, 0);
        n0 = wb_count;
        do_op(1'b0, mk_addr(20'h0D003, 7'd40, 3'd0), '0, '0, 0);
        wait_wb_idle();
        check_val("dirty eviction writes", wb_count, n0 + 1);
        check_val("dirty eviction address", last_wb_addr, mk_addr(20'h0D001, 7'd40, 3'd0));
        n0 = wb_count;
        do_op(1'b0, mk_addr(20'h0D004, 7'd40, 3'd0), '0, '0, 0);
        wait_wb_idle();
        check_val("clean eviction writes", wb_count, n0);
        do_op(1'b0, mk_addr(20'h0D001, 7'd40, 3'd2), '0, '0, 0);

        // random mix over 4 tags and 2 sets
        for (int n = 0; n < 300; n++) begin
            op_wr = rand_bits(1);
            a = mk_addr(dcache_pkg::tag_t'(20'h00A40 + rand_bits(2)),
                        dcache_pkg::index_t'(7'd5 + rand_bits(1)),
                        dcache_pkg::bank_sel_t'(rand_bits(3)));
            do_op(op_wr, a, rand_bits(32), dcache_pkg::wsel_t'(rand_bits(4)), 2);
        end
        wait_wb_idle();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache_proj.f
common/dcache_pkg.sv
verilog/writeback_buffer.sv
dcache/dcache_data_array.sv
dcache/dcache_tag_store.sv
dcache/dcache_ctrl.sv
verilog/dcache_top.sv
tb/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache_proj

sources:
  - common/dcache_pkg.sv
  - verilog/writeback_buffer.sv
  - dcache/dcache_data_array.sv
  - dcache/dcache_tag_store.sv
  - dcache/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: simulation
    files:
      - tb/tb_dcache.sv
